// ==== source/emesh_pkg.sv ====
// ------------------------------------------------------------
// emesh packet widths, input packet and translated packet
// ------------------------------------------------------------
package emesh_pkg;

   localparam int EMESH_AW        = 32;  // packet address width
   localparam int EMESH_DW        = 32;  // packet data width
   localparam int EMESH_PAW       = 64;  // physical addr after mmu
   localparam int EMESH_PAGE_BITS = 20;  // low bits passed untranslated

   // packet as it enters the mmu
   typedef struct packed {
      logic                 write;
      logic [1:0]           datamode;
      logic [3:0]           ctrlmode;
      logic [EMESH_AW-1:0]  dstaddr;
      logic [EMESH_AW-1:0]  srcaddr;
      logic [EMESH_DW-1:0]  data;
   } emesh_packet_t;

   // packet after translation, only dstaddr grows
   typedef struct packed {
      logic                 write;
      logic [1:0]           datamode;
      logic [3:0]           ctrlmode;
      logic [EMESH_PAW-1:0] dstaddr;   // 64b physical
      logic [EMESH_AW-1:0]  srcaddr;
      logic [EMESH_DW-1:0]  data;
   } emesh_xlate_t;

endpackage

// ==== source/mmu_pkg.sv ====
// ------------------------------------------------------------
// mmu table geometry, config access struct, entry/lane types
// ------------------------------------------------------------
package mmu_pkg;

   localparam int MMU_IDW      = 12;            // table index width
   localparam int MMU_DEPTH    = 1 << MMU_IDW;  // 4096 entries
   localparam int MMU_ENTRY_W  = 48;            // stored bits per entry
   localparam int MMU_XLATE_W  = 44;            // bits used for translation
   localparam int MMU_LANES    = MMU_ENTRY_W / 8;
   localparam int MMU_CFG_AW   = 16;            // config address width
   localparam int MMU_CFG_DW   = 32;            // config data word
   localparam int MMU_WE_W     = MMU_CFG_DW / 8;
   localparam int MMU_HI_W     = MMU_ENTRY_W - MMU_CFG_DW;  // 16b high word
   localparam int MMU_WORD_BIT = 2;             // addr bit picking hi/lo word
   localparam int MMU_IDX_LSB  = 3;             // entry index starts here

   // one config port access
   typedef struct packed {
      logic                  en;
      logic [MMU_WE_W-1:0]   we;     // byte enables, all zero = read
      logic [MMU_CFG_AW-1:0] addr;
      logic [MMU_CFG_DW-1:0] din;
   } mmu_cfg_t;

   // table entry, top bits stored but unused by lookup
   typedef struct packed {
      logic [MMU_ENTRY_W-MMU_XLATE_W-1:0] spare;
      logic [MMU_XLATE_W-1:0]             xlate;
   } mmu_entry_t;

   typedef logic [MMU_LANES-1:0] mmu_lane_t;

endpackage

// ==== source/mmu_cfg_decode.sv ====
// ------------------------------------------------------------
// config port decode, lane enables and readback word select
// ------------------------------------------------------------
`timescale 1ns/1ps

module mmu_cfg_decode
   import mmu_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  mmu_cfg_t              cfg,
   output logic [MMU_IDW-1:0]    wr_index,
   output mmu_lane_t             wr_lanes,
   output mmu_entry_t            wr_data,
   output logic                  rd_en,
   output logic [MMU_IDW-1:0]    rd_index,
   input  mmu_entry_t            rd_entry,
   output logic [MMU_CFG_DW-1:0] cfg_rdata
);

   logic wr_access;   // en with some byte enable
   logic hi_word;     // addr bit 2
   logic hi_sel_q;    // word select of last read
   logic rd_done_q;   // a read has completed since reset

   assign hi_word   = cfg.addr[MMU_WORD_BIT];
   assign wr_access = cfg.en & (|cfg.we);
   assign rd_en     = cfg.en & ~(|cfg.we);

   // same entry index for both directions
   assign wr_index = cfg.addr[MMU_IDX_LSB +: MMU_IDW];
   assign rd_index = cfg.addr[MMU_IDX_LSB +: MMU_IDW];

   // din copied to both halves, lanes pick which bytes land
   assign wr_data = {cfg.din[MMU_HI_W-1:0], cfg.din};

   always_comb
   begin
      wr_lanes = '0;
      if (wr_access && !hi_word)
         wr_lanes = {{(MMU_LANES-MMU_WE_W){1'b0}}, cfg.we};          // bytes 3:0
      else if (wr_access && hi_word)
         wr_lanes = {cfg.we[MMU_LANES-MMU_WE_W-1:0], {MMU_WE_W{1'b0}}};  // we 3:2 dropped
   end

   // table rd port is the data register, only word select kept here
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hi_sel_q  <= 1'b0;
         rd_done_q <= 1'b0;
      end
      else if (rd_en)
      begin
         hi_sel_q  <= hi_word;
         rd_done_q <= 1'b1;
      end
   end

   // rd_entry holds between reads, so the mux output holds too
   assign cfg_rdata = !rd_done_q ? '0 :
                      hi_sel_q   ? {{(MMU_CFG_DW-MMU_HI_W){1'b0}},
                                    rd_entry[MMU_ENTRY_W-1:MMU_CFG_DW]} :
                                   rd_entry[MMU_CFG_DW-1:0];

   // an unknown index would hit an unknown entry
   a_cfg_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(cfg.en) &&
      (!cfg.en || !$isunknown({cfg.we, cfg.addr[MMU_IDX_LSB +: MMU_IDW]})));

endmodule

// ==== source/mmu_table.sv ====
// ------------------------------------------------------------
// 4096x48 translation table, byte-lane cfg port plus lookup
// ------------------------------------------------------------
`timescale 1ns/1ps

module mmu_table
   import mmu_pkg::*;
(
   input  logic               clk,
   input  logic [MMU_IDW-1:0] wr_index,
   input  logic [MMU_IDW-1:0] rd_index,
   input  logic [MMU_IDW-1:0] lookup_index,
   input  mmu_lane_t          wr_lanes,
   input  mmu_entry_t         wr_data,
   input  logic               rd_en,
   input  logic               lookup_en,
   output mmu_entry_t         rd_entry,
   output mmu_entry_t         lookup_entry
);

   // contents undefined until software writes them
   mmu_entry_t mem [MMU_DEPTH];

   // per-byte write from the config side
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < MMU_LANES; i++)
      begin
         if (wr_lanes[i])
            mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
      end
   end

   // config readback port
   // nonblocking read sees the entry as it was before a same-cycle write
   always_ff @(posedge clk)
   begin
      if (rd_en)
         rd_entry <= mem[rd_index];
   end

   // packet lookup port, one cycle latency matches emmu's register
   always_ff @(posedge clk)
   begin
      if (lookup_en)
         lookup_entry <= mem[lookup_index];  // old data on collision
   end

   // lanes come from the decoder, an X there corrupts an entry silently
   a_lanes_known: assert property (@(posedge clk)
      !$isunknown(wr_lanes));

endmodule

// ==== source/emmu.sv ====
// ------------------------------------------------------------
// packet stage, registers packet and builds 64b dstaddr
// ------------------------------------------------------------
`timescale 1ns/1ps

module emmu
   import emesh_pkg::*;
   import mmu_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          mmu_en,
   input  logic          packet_valid,
   input  emesh_packet_t packet_in,
   input  mmu_entry_t    lookup_entry,
   output logic          xlate_valid,
   output emesh_xlate_t  xlate_out
);

   emesh_packet_t pkt_q;    // payload, no reset
   logic          en_q;     // mmu_en taken with the packet

   // valid every cycle, lines up with the table read
   always_ff @(posedge clk)
   begin
      if (reset)
         xlate_valid <= 1'b0;
      else
         xlate_valid <= packet_valid;
   end

   // payload only moves on a valid packet
   always_ff @(posedge clk)
   begin
      if (packet_valid)
      begin
         pkt_q <= packet_in;
         en_q  <= mmu_en;
      end
   end

   // output fields straight from the register
   always_comb
   begin
      xlate_out.write    = pkt_q.write;
      xlate_out.datamode = pkt_q.datamode;
      xlate_out.ctrlmode = pkt_q.ctrlmode;
      xlate_out.srcaddr  = pkt_q.srcaddr;
      xlate_out.data     = pkt_q.data;
      if (en_q)
      begin
         // 44 xlate bits over the 20b page offset
         xlate_out.dstaddr = {lookup_entry.xlate,
                              pkt_q.dstaddr[EMESH_PAGE_BITS-1:0]};
      end
      else
      begin
         xlate_out.dstaddr = {{(EMESH_PAW-EMESH_AW){1'b0}}, pkt_q.dstaddr};  // bypass
      end
   end

   // downstream has no backpressure, a bad valid is unrecoverable
   a_valid_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(xlate_valid));

endmodule

// ==== source/emmu_top.sv ====
// ------------------------------------------------------------
// mmu top, cfg decoder + table + packet translator
// ------------------------------------------------------------
`timescale 1ns/1ps

module emmu_top
   import emesh_pkg::*;
   import mmu_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mmu_en,
   input  logic                  packet_valid,
   input  emesh_packet_t         packet_in,
   input  mmu_cfg_t              cfg,
   output logic                  xlate_valid,
   output emesh_xlate_t          xlate_out,
   output logic [MMU_CFG_DW-1:0] cfg_rdata
);

   logic [MMU_IDW-1:0] wr_index;
   logic [MMU_IDW-1:0] rd_index;
   mmu_lane_t          wr_lanes;
   mmu_entry_t         wr_data;
   mmu_entry_t         rd_entry;
   mmu_entry_t         lookup_entry;
   logic               rd_en;

   mmu_cfg_decode mmu_cfg_decode_inst (
      .clk       (clk),
      .reset     (reset),
      .cfg       (cfg),
      .wr_index  (wr_index),
      .wr_lanes  (wr_lanes),
      .wr_data   (wr_data),
      .rd_en     (rd_en),
      .rd_index  (rd_index),
      .rd_entry  (rd_entry),
      .cfg_rdata (cfg_rdata)
   );

   // lookup index is dstaddr 31:20
   mmu_table mmu_table_inst (
      .clk          (clk),
      .wr_index     (wr_index),
      .rd_index     (rd_index),
      .lookup_index (packet_in.dstaddr[EMESH_AW-1 -: MMU_IDW]),
      .wr_lanes     (wr_lanes),
      .wr_data      (wr_data),
      .rd_en        (rd_en),
      .lookup_en    (packet_valid),
      .rd_entry     (rd_entry),
      .lookup_entry (lookup_entry)
   );

   emmu emmu_inst (
      .clk          (clk),
      .reset        (reset),
      .mmu_en       (mmu_en),
      .packet_valid (packet_valid),
      .packet_in    (packet_in),
      .lookup_entry (lookup_entry),
      .xlate_valid  (xlate_valid),
      .xlate_out    (xlate_out)
   );

endmodule

// ==== tests/emmu_tb.sv ====
// ------------------------------------------------------------
// emmu_top testbench, lcg stimulus against a shadow table
// ------------------------------------------------------------
`timescale 1ns/1ps

module emmu_tb
   import emesh_pkg::*;
   import mmu_pkg::*;
();

   localparam int N_IDX   = 16;   // lookup pool size
   localparam int N_BYTE  = 48;   // partial byte-enable writes
   localparam int N_PKT   = 200;  // packets per translation phase
   localparam int N_MIX   = 64;   // write then lookup rounds
   localparam int MAX_GAP = 2;    // idle cycles between packets
   localparam int STIM_CYCLES = 8 + 6 * N_IDX + N_BYTE + 2 * N_PKT * (1 + MAX_GAP)
                                + 2 * N_MIX + 1;
   localparam int TIMEOUT = 2 * STIM_CYCLES + 100;

   logic                  clk;
   logic                  reset;
   logic                  mmu_en;
   logic                  packet_valid;
   emesh_packet_t         packet_in;
   mmu_cfg_t              cfg;
   logic                  xlate_valid;
   emesh_xlate_t          xlate_out;
   logic [MMU_CFG_DW-1:0] cfg_rdata;

   logic [31:0]        seed = 32'd10;
   logic [47:0]        model [MMU_DEPTH];   // shadow table
   logic [1:0]         mark [MMU_DEPTH];    // bit0 low full, bit1 high full
   logic [MMU_IDW-1:0] pool [N_IDX];
   string              test_name;
   int                 cycles = 0;
   logic               pend_valid;          // one-deep expected pipeline
   emesh_xlate_t       pend_xlate;
   logic               pend_rd;             // rdata checked every cycle once set
   logic [31:0]        pend_rdata;
   string              exp_name;            // expectations taken at the rising edge
   logic               exp_valid;
   emesh_xlate_t       exp_xlate;
   logic               exp_rd;
   logic [31:0]        exp_rdata;

   emmu_top emmu_top_inst (
      .clk          (clk),
      .reset        (reset),
      .mmu_en       (mmu_en),
      .packet_valid (packet_valid),
      .packet_in    (packet_in),
      .cfg          (cfg),
      .xlate_valid  (xlate_valid),
      .xlate_out    (xlate_out),
      .cfg_rdata    (cfg_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > TIMEOUT)
      begin
         $display("run stopped after %0d cycles, stimulus never finished", cycles);
         $display("Result: FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed;
   endfunction

   // upper halves only, low lcg bits cycle fast
   function automatic logic [31:0] rand_word();
      logic [31:0] a;
      logic [31:0] b;
      a = lcg_next();
      b = lcg_next();
      return {a[31:16], b[31:16]};
   endfunction

   function automatic logic [3:0] pool_slot();
      logic [31:0] r;
      r = rand_word();
      return r[3:0];
   endfunction

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[FAIL] %s expected %b actual %b", name, exp, act);
         $display("Result: FAILED");
         $fatal(1, "valid mismatch");
      end
   endtask

   task automatic check_xlate(input string name, input emesh_xlate_t exp,
                              input emesh_xlate_t act);
      if (act !== exp)
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("Result: FAILED");
         $fatal(1, "packet mismatch");
      end
   endtask

   task automatic check_rdata(input string name, input logic [MMU_CFG_DW-1:0] exp,
                              input logic [MMU_CFG_DW-1:0] act);
      if (act !== exp)
      begin
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         $display("Result: FAILED");
         $fatal(1, "readback mismatch");
      end
   endtask

   // sampled 5 ns after the falling edge, once the next inputs have landed
   always @(posedge clk)
   begin
      exp_name  = test_name;
      exp_valid = pend_valid;
      exp_xlate = pend_xlate;
      exp_rd    = pend_rd;
      exp_rdata = pend_rdata;
      #15;
      check_valid({exp_name, " xlate_valid"}, exp_valid, xlate_valid);
      if (exp_valid)
         check_xlate(exp_name, exp_xlate, xlate_out);
      if (exp_rd)
         check_rdata(exp_name, exp_rdata, cfg_rdata);
   end

   // next falling edge, then idle unless the caller drives again
   task automatic tick();
      @(negedge clk);
      pend_valid   = 1'b0;
      cfg          = '0;
      packet_valid = 1'b0;
      mmu_en       = ~mmu_en;  // must not leak into a packet already taken
   endtask

   task automatic cfg_write(input logic [MMU_IDW-1:0] idx, input logic hi,
                            input logic [3:0] we, input logic [31:0] din);
      cfg.en   = 1'b1;
      cfg.we   = we;
      cfg.addr = {1'b0, idx, hi, 2'b00};
      cfg.din  = din;
      for (int b = 0; b < 4; b++)
      begin
         if (we[b] && !hi)
            model[idx][8*b +: 8] = din[8*b +: 8];
         else if (we[b] && hi && b < 2)
            model[idx][32 + 8*b +: 8] = din[8*b +: 8];  // only 2 bytes up top
      end
      if (!hi && we == 4'hf)
         mark[idx][0] = 1'b1;
      if (hi && we[1:0] == 2'b11)
         mark[idx][1] = 1'b1;
      tick();
   endtask

   task automatic cfg_read(input logic [MMU_IDW-1:0] idx, input logic hi);
      cfg.en     = 1'b1;
      cfg.we     = '0;
      cfg.addr   = {1'b0, idx, hi, 2'b11};  // low addr bits ignored
      cfg.din    = rand_word();
      pend_rd    = 1'b1;
      pend_rdata = hi ? {16'h0, model[idx][47:32]} : model[idx][31:0];
      tick();
   endtask

   task automatic send_packet(input logic [MMU_IDW-1:0] idx, input logic en);
      emesh_packet_t pkt;
      logic [31:0]   r;
      r = rand_word();
      pkt.write    = r[0];
      pkt.datamode = r[2:1];
      pkt.ctrlmode = r[6:3];
      pkt.dstaddr  = {idx, r[31:12]};  // page index on top
      pkt.srcaddr  = rand_word();
      pkt.data     = rand_word();
      if (en && mark[idx] != 2'b11)
      begin
         $display("lookup of entry %h that was never fully written", idx);
         $display("Result: FAILED");
         $fatal(1, "stimulus error");
      end
      packet_in    = pkt;
      packet_valid = 1'b1;
      mmu_en       = en;
      pend_valid   = 1'b1;
      pend_xlate.write    = pkt.write;
      pend_xlate.datamode = pkt.datamode;
      pend_xlate.ctrlmode = pkt.ctrlmode;
      pend_xlate.srcaddr  = pkt.srcaddr;
      pend_xlate.data     = pkt.data;
      if (en)
         pend_xlate.dstaddr = {model[idx][43:0], pkt.dstaddr[19:0]};
      else
         pend_xlate.dstaddr = {32'h0, pkt.dstaddr};
      tick();
   endtask

   initial
   begin
      logic [31:0] r;
      logic [3:0]  we;
      reset        = 1'b1;
      mmu_en       = 1'b0;
      packet_valid = 1'b0;
      packet_in    = '0;
      cfg          = '0;
      pend_valid   = 1'b0;
      pend_rd      = 1'b0;
      test_name    = "reset";
      for (int i = 0; i < MMU_DEPTH; i++)
         mark[i] = 2'b00;
      for (int i = 0; i < N_IDX; i++)
      begin
         r       = rand_word();
         pool[i] = r[MMU_IDW-1:0];
      end
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (3)
      begin
         pend_rd    = 1'b1;  // rdata must sit at zero
         pend_rdata = '0;
         tick();
      end
      test_name = "full_word";
      for (int i = 0; i < N_IDX; i++)
      begin
         cfg_write(pool[i], 1'b0, 4'hf, rand_word());
         cfg_write(pool[i], 1'b1, 4'hf, rand_word());  // din 31:16 dropped
      end
      for (int i = 0; i < N_IDX; i++)
      begin
         cfg_read(pool[i], 1'b0);
         cfg_read(pool[i], 1'b1);
      end
      test_name = "byte_lane";
      repeat (N_BYTE)
      begin
         r  = rand_word();
         we = (r[8:5] == 4'h0) ? 4'h1 : r[8:5];  // zero we would be a read
         cfg_write(pool[r[3:0]], r[4], we, rand_word());
      end
      for (int i = 0; i < N_IDX; i++)
      begin
         cfg_read(pool[i], 1'b0);
         cfg_read(pool[i], 1'b1);
      end
      test_name = "xlate_on";
      repeat (N_PKT)
      begin
         send_packet(pool[pool_slot()], 1'b1);
         repeat (rand_word() % (MAX_GAP + 1)) tick();  // zero gap = back to back
      end
      test_name = "xlate_off";
      repeat (N_PKT)
      begin
         send_packet(pool[pool_slot()], 1'b0);
         repeat (rand_word() % (MAX_GAP + 1)) tick();
      end
      test_name = "write_then_lookup";
      repeat (N_MIX)
      begin
         r  = rand_word();
         we = (r[8:5] == 4'h0) ? 4'hf : r[8:5];
         cfg_write(pool[r[3:0]], r[4], we, rand_word());
         send_packet(pool[r[3:0]], 1'b1);  // lookup one cycle after write
      end
      tick();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
source/emesh_pkg.sv
source/mmu_pkg.sv
source/mmu_cfg_decode.sv
source/mmu_table.sv
source/emmu.sv
source/emmu_top.sv
tests/emmu_tb.sv

// ==== Makefile ====
# Verilator build and run for the emmu testbench

TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = emmu_tb
FILELIST = filelist.f
BUILD    = obj_dir

.PHONY: sim clean

# pass only when the pass line shows up in the simulation output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD)
